// File: decode_stage.f
common/decode_pkg.sv
design/inst_fifo.sv
decoder/format_classifier.sv
decoder/alu_op_decoder.sv
decoder/mem_op_decoder.sv
decoder/ctrl_decoder.sv
design/decode_stage.sv
verification/decode_stage_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module decode_stage_tb \
		-f decode_stage.f --Mdir obj_dir -o decode_stage_sim
	out="$$(./obj_dir/decode_stage_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: verification/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
    import decode_pkg::*;

    logic            clk;
    logic            rst;
    logic            inst_valid;
    logic [xlen-1:0] inst;
    logic            in_credit;
    logic            out_valid;
    decoded_t        out;
    logic            out_credit;

    logic [xlen-1:0] rows_inst[$];                   // stimulus table
    decoded_t        rows_exp[$];                    // expected result per row
    logic [xlen-1:0] send_q[$];                      // upstream waiting list
    decoded_t        exp_q[$];                       // expected at the output, in order

    int cyc;
    int errors;
    int tests_run;
    int tests_failed;
    int hung;
    int n_kept;                                      // rows before the safe default ones
    int up_credits;                                  // credits upstream holds
    int sent;
    int in_pulses;
    int recv;
    int owed;                                        // credits downstream still owes
    int ret_mode;                                    // 0 at once, 1 withheld, 2 random gaps
    int accept_cyc;
    int last_out_cyc;
    logic credit_prev;                               // in_credit seen in the cycle before

    decode_stage dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out        (out),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic ctrl_t bundle(input logic wen, input a_src_e a, input b_src_e b,
                                     input alu_op_e op, input logic mw, input wb_src_e wb,
                                     input logic sgn, input data_size_e sz);
        ctrl_t c;
        c.reg_wen   = wen;
        c.a_src     = a;
        c.b_src     = b;
        c.alu_op    = op;
        c.mem_write = mw;
        c.wb_src    = wb;
        c.is_signed = sgn;
        c.data_size = sz;
        return c;
    endfunction

    // flags are {is_br, is_jal, is_jalr}
    task automatic add_row(input logic [xlen-1:0] w, input ctrl_t c, input imm_type_e t,
                           input logic [2:0] flags);
        decoded_t d;
        d.inst     = w;
        d.ctrl     = c;
        d.imm_type = t;
        d.br_op    = w[14:12];
        d.is_br    = flags[2];
        d.is_jal   = flags[1];
        d.is_jalr  = flags[0];
        rows_inst.push_back(w);
        rows_exp.push_back(d);
    endtask

    task automatic alu_row(input logic [xlen-1:0] w, input alu_op_e op, input logic sgn);
        logic is_reg;
        is_reg = (w[6:0] == opc_op);
        add_row(w, bundle(1'b1, a_rs1, is_reg ? b_rs2 : b_imm, op, 1'b0, wb_alu, sgn,
                          size_none), is_reg ? imm_r : imm_i, 3'b000);
    endtask

    task automatic load_row(input logic [xlen-1:0] w, input data_size_e sz, input logic sgn);
        add_row(w, bundle(1'b1, a_rs1, b_imm, alu_add, 1'b0, wb_mem, sgn, sz), imm_i, 3'b000);
    endtask

    task automatic store_row(input logic [xlen-1:0] w, input data_size_e sz);
        add_row(w, bundle(1'b0, a_rs1, b_imm, alu_add, 1'b1, wb_none, 1'b0, sz), imm_s, 3'b000);
    endtask

    task automatic branch_row(input logic [xlen-1:0] w, input logic sgn);
        add_row(w, bundle(1'b0, a_pc, b_imm, alu_add, 1'b0, wb_none, sgn, size_none),
                imm_b, 3'b100);
    endtask

    task automatic safe_row(input logic [xlen-1:0] w, input imm_type_e t);
        add_row(w, bundle(1'b0, a_rs1, b_rs2, alu_add, 1'b0, wb_none, 1'b0, size_none),
                t, 3'b000);
    endtask

    task automatic build_table();
        alu_row(32'h003100B3, alu_add, 1'b0);       // add x1, x2, x3
        alu_row(32'h403100B3, alu_sub, 1'b0);
        alu_row(32'h003110B3, alu_sll, 1'b0);
        alu_row(32'h003120B3, alu_slt, 1'b1);       // slt
        alu_row(32'h003130B3, alu_slt, 1'b0);       // sltu
        alu_row(32'h003140B3, alu_xor, 1'b0);
        alu_row(32'h003150B3, alu_srl, 1'b0);       // srl
        alu_row(32'h403150B3, alu_srl, 1'b1);       // sra
        alu_row(32'h003160B3, alu_or,  1'b0);
        alu_row(32'h003170B3, alu_and, 1'b0);
        alu_row(32'h00510093, alu_add, 1'b0);       // addi x1, x2, 5
        alu_row(32'h00512093, alu_slt, 1'b1);       // slti
        alu_row(32'h00513093, alu_slt, 1'b0);       // sltiu
        alu_row(32'h00514093, alu_xor, 1'b0);
        alu_row(32'h00516093, alu_or,  1'b0);
        alu_row(32'h00517093, alu_and, 1'b0);
        alu_row(32'h00511093, alu_sll, 1'b0);       // slli
        alu_row(32'h00515093, alu_srl, 1'b0);       // srli
        alu_row(32'h40515093, alu_srl, 1'b1);       // srai
        load_row(32'h00810083, size_byte, 1'b1);    // lb x1, 8(x2)
        load_row(32'h00811083, size_half, 1'b1);
        load_row(32'h00812083, size_word, 1'b1);
        load_row(32'h00814083, size_byte, 1'b0);    // lbu
        load_row(32'h00815083, size_half, 1'b0);    // lhu
        store_row(32'h00310423, size_byte);         // sb x3, 8(x2)
        store_row(32'h00311423, size_half);
        store_row(32'h00312423, size_word);
        branch_row(32'h00310463, 1'b0);             // beq, offset 8
        branch_row(32'h00311463, 1'b0);
        branch_row(32'h00314463, 1'b1);             // blt
        branch_row(32'h00315463, 1'b1);             // bge
        branch_row(32'h00316463, 1'b0);
        branch_row(32'h00317463, 1'b0);
        add_row(32'h123450B7, bundle(1'b1, a_rs1, b_imm, alu_pass, 1'b0, wb_alu, 1'b0,
                                     size_none), imm_u, 3'b000);    // lui
        add_row(32'h12345097, bundle(1'b1, a_pc, b_imm, alu_add, 1'b0, wb_alu, 1'b0,
                                     size_none), imm_u, 3'b000);    // auipc
        add_row(32'h008000EF, bundle(1'b1, a_pc, b_imm, alu_add, 1'b0, wb_snpc, 1'b0,
                                     size_none), imm_j, 3'b010);    // jal x1, 8
        add_row(32'h004100E7, bundle(1'b1, a_rs1, b_imm, alu_add, 1'b0, wb_snpc, 1'b0,
                                     size_none), imm_i, 3'b001);    // jalr x1, 4(x2)
        n_kept = rows_inst.size();
        safe_row(32'h0FF0000F, imm_i);              // fence
        safe_row(32'h00000073, imm_i);              // ecall
        safe_row(32'h00100073, imm_i);              // ebreak
        safe_row(32'h0000507F, imm_unused);         // unknown opcode
        safe_row(32'h00813083, imm_i);              // load, funct3 011
    endtask

    task automatic queue_rows(input int first, input int n);
        for (int i = first; i < first + n; i++) begin
            send_q.push_back(rows_inst[i]);
            exp_q.push_back(rows_exp[i]);
        end
    endtask

    // one clock: sample what the last edge produced, then drive the next inputs
    task automatic step();
        decoded_t e;
        logic     got_credit;
        @(posedge clk);
        #2;
        cyc++;
        got_credit = in_credit;
        if (in_credit) begin
            in_pulses++;
        end
        assert (in_pulses <= sent) else begin
            $display("ERR %0t: upstream credits off, sent %0d returned %0d",
                     $time, sent, in_pulses);
            errors++;
        end
        // a pop returns its credit in the same cycle and shows on out one cycle later
        assert (out_valid === credit_prev) else begin
            $display("ERR %0t: out_valid %b but in_credit was %b the cycle before",
                     $time, out_valid, credit_prev);
            errors++;
        end
        if (out_valid) begin
            recv++;
            owed++;
            last_out_cyc = cyc;
            assert (exp_q.size() > 0) else begin
                $display("ERR %0t: output %08h with nothing expected", $time, out.inst);
                errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (out === e) else begin
                    $display("ERR %0t: inst %08h gave %h, expected %h for %08h",
                             $time, out.inst, out, e, e.inst);
                    errors++;
                end
            end
        end
        out_credit = 1'b0;
        if (owed > 0 && (ret_mode == 0 || (ret_mode == 2 && ($urandom % 4) == 0))) begin
            out_credit = 1'b1;
            owed--;
        end
        inst_valid = 1'b0;
        if (send_q.size() > 0 && up_credits > 0) begin
            inst       = send_q.pop_front();
            inst_valid = 1'b1;
            up_credits--;
            sent++;
            accept_cyc = cyc;                        // valid during this cycle
        end
        if (got_credit) begin
            up_credits++;                            // usable from the next cycle
        end
        credit_prev = got_credit;
    endtask

    // run until everything is delivered and all credits are home
    task automatic drain(input int limit, input string what);
        int n;
        n = 0;
        while (!(send_q.size() == 0 && exp_q.size() == 0 && owed == 0 &&
                 up_credits == fifo_depth) && n < limit) begin
            step();
            n++;
        end
        if (n == limit) begin
            $display("timeout: %s did not complete within %0d cycles", what, limit);
            hung = 1;
        end
    endtask

    task automatic report(input string name, input int err0);
        tests_run++;
        if (errors == err0 && hung == 0) begin
            $display("test %-22s ok", name);
        end else begin
            tests_failed++;
            $display("test %-22s fail, %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        int err0;
        int recv0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        out_credit = 1'b0;
        cyc = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        hung = 0;
        up_credits = fifo_depth;
        sent = 0;
        in_pulses = 0;
        recv = 0;
        owed = 0;
        ret_mode = 0;
        accept_cyc = 0;
        last_out_cyc = 0;
        credit_prev = 1'b0;
        void'($urandom(32'h1930ab89));
        build_table();

        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            step();
            if (i == 3) begin
                rst = 1'b0;                          // after the 4th edge
            end
            assert (!out_valid && !in_credit) else begin
                $display("ERR %0t: activity with no input, cycle %0d", $time, cyc);
                errors++;
            end
        end
        report("reset", err0);

        err0 = errors;
        queue_rows(0, n_kept);
        drain(500, "decode table stream");
        report("decode table", err0);

        if (hung == 0) begin
            err0 = errors;
            queue_rows(n_kept, rows_inst.size() - n_kept);
            drain(100, "safe default stream");
            report("safe default", err0);
        end

        if (hung == 0) begin
            err0 = errors;
            queue_rows(0, 1);
            drain(20, "single instruction");
            assert (last_out_cyc - accept_cyc == 2) else begin
                $display("ERR %0t: latency %0d cycles, expected 2",
                         $time, last_out_cyc - accept_cyc);
                errors++;
            end
            report("latency", err0);
        end

        if (hung == 0) begin
            err0 = errors;
            recv0 = recv;
            ret_mode = 1;
            queue_rows(0, rows_inst.size());
            for (int i = 0; i < 30; i++) begin
                step();
            end
            assert (recv - recv0 <= out_credits) else begin
                $display("ERR %0t: %0d results while credits withheld", $time, recv - recv0);
                errors++;
            end
            ret_mode = 2;
            drain(3000, "back-pressure release");
            assert (recv - recv0 == rows_inst.size()) else begin
                $display("ERR %0t: %0d results, expected %0d",
                         $time, recv - recv0, rows_inst.size());
                errors++;
            end
            report("back-pressure", err0);
        end

        err0 = errors;
        assert (in_pulses == sent) else begin
            $display("ERR %0t: %0d input credits for %0d sent", $time, in_pulses, sent);
            errors++;
        end
        report("input credits", err0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && hung == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  logic [decode_pkg::xlen-1:0] inst,
    output logic                        in_credit,
    output logic                        out_valid,
    output decode_pkg::decoded_t        out,
    input  logic                        out_credit
);
    import decode_pkg::*;

    logic [xlen-1:0]     fifo_inst;
    logic                fifo_empty;
    logic                pop;
    logic [credit_w-1:0] credit_cnt;                 // credits held toward downstream
    decoded_t            dec;

    // send only with something buffered and a credit in hand
    assign pop = !fifo_empty && (credit_cnt != '0);

    inst_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (inst_valid),
        .push_data (inst),
        .pop       (pop),
        .pop_data  (fifo_inst),
        .empty     (fifo_empty),
        .credit    (in_credit)
    );

    ctrl_decoder u_dec (
        .inst (fifo_inst),
        .dec  (dec)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_w'(out_credits);
        end else begin
            case ({pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;   // send and return cancel
            endcase
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out <= dec;
        end
    end

endmodule

// File: decoder/ctrl_decoder.sv
`timescale 1ns/10ps

module ctrl_decoder (
    input  logic [decode_pkg::xlen-1:0] inst,
    output decode_pkg::decoded_t        dec
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    imm_type_e  imm_type;
    itype_sub_e itype_sub;
    ctrl_t      alu_ctrl;
    ctrl_t      mem_ctrl;
    ctrl_t      u_ctrl;
    ctrl_t      jal_ctrl;
    ctrl_t      jalr_ctrl;
    ctrl_t      br_ctrl;
    ctrl_t      ctrl;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    format_classifier u_fmt (
        .opcode    (opcode),
        .imm_type  (imm_type),
        .itype_sub (itype_sub)
    );

    alu_op_decoder u_alu_dec (
        .funct3    (funct3),
        .funct7_b5 (inst[30]),
        .is_reg    (imm_type == imm_r),
        .ctrl      (alu_ctrl)
    );

    mem_op_decoder u_mem_dec (
        .funct3   (funct3),
        .is_store (imm_type == imm_s),
        .ctrl     (mem_ctrl)
    );

    // U, jump and branch bundles
    always_comb begin
        u_ctrl         = ctrl_default;
        u_ctrl.reg_wen = 1'b1;
        u_ctrl.b_src   = b_imm;
        u_ctrl.wb_src  = wb_alu;
        if (opcode[5]) begin                         // lui
            u_ctrl.alu_op = alu_pass;
        end else begin                               // auipc
            u_ctrl.a_src  = a_pc;
            u_ctrl.alu_op = alu_add;
        end

        jal_ctrl         = ctrl_default;
        jal_ctrl.reg_wen = 1'b1;
        jal_ctrl.a_src   = a_pc;
        jal_ctrl.b_src   = b_imm;
        jal_ctrl.wb_src  = wb_snpc;

        jalr_ctrl         = jal_ctrl;
        jalr_ctrl.a_src   = a_rs1;                   // target from rs1 + imm

        br_ctrl = ctrl_default;
        if (funct3[2:1] != 2'b01) begin              // 010 and 011 undefined
            br_ctrl.a_src     = a_pc;
            br_ctrl.b_src     = b_imm;
            br_ctrl.is_signed = (funct3[2:1] == 2'b10);  // blt, bge
        end
    end

    always_comb begin
        case (imm_type)
            imm_u: ctrl = u_ctrl;
            imm_j: ctrl = jal_ctrl;
            imm_i: begin
                case (itype_sub)
                    isub_uncond_jump: ctrl = jalr_ctrl;
                    isub_load:        ctrl = mem_ctrl;
                    isub_operation:   ctrl = alu_ctrl;
                    default:          ctrl = ctrl_default;
                endcase
            end
            imm_s:   ctrl = mem_ctrl;
            imm_b:   ctrl = br_ctrl;
            imm_r:   ctrl = alu_ctrl;
            default: ctrl = ctrl_default;
        endcase
    end

    assign dec.inst     = inst;
    assign dec.ctrl     = ctrl;
    assign dec.imm_type = imm_type;
    assign dec.br_op    = funct3;
    assign dec.is_br    = (imm_type == imm_b);
    assign dec.is_jal   = (imm_type == imm_j);
    assign dec.is_jalr  = (itype_sub == isub_uncond_jump);

endmodule

// File: decoder/mem_op_decoder.sv
`timescale 1ns/10ps

module mem_op_decoder (
    input  logic [2:0]        funct3,
    input  logic              is_store,
    output decode_pkg::ctrl_t ctrl
);
    import decode_pkg::*;

    logic       valid;
    data_size_e size;
    logic       sgn;

    always_comb begin
        valid = 1'b1;
        size  = size_none;
        sgn   = 1'b0;
        if (is_store) begin
            case (funct3)
                3'b000:  size = size_byte;           // sb
                3'b001:  size = size_half;           // sh
                3'b010:  size = size_word;           // sw
                default: valid = 1'b0;
            endcase
        end else begin
            case (funct3)
                3'b000: begin                        // lb
                    size = size_byte;
                    sgn  = 1'b1;
                end
                3'b001: begin                        // lh
                    size = size_half;
                    sgn  = 1'b1;
                end
                3'b010: begin                        // lw
                    size = size_word;
                    sgn  = 1'b1;
                end
                3'b100:  size = size_byte;           // lbu
                3'b101:  size = size_half;           // lhu
                default: valid = 1'b0;
            endcase
        end
    end

    // address is always rs1 + imm
    always_comb begin
        ctrl = ctrl_default;
        if (valid) begin
            ctrl.reg_wen   = !is_store;
            ctrl.a_src     = a_rs1;
            ctrl.b_src     = b_imm;
            ctrl.alu_op    = alu_add;
            ctrl.mem_write = is_store;
            ctrl.wb_src    = is_store ? wb_none : wb_mem;
            ctrl.is_signed = sgn;                    // stores leave it 0
            ctrl.data_size = size;
        end
    end

endmodule

// File: decoder/alu_op_decoder.sv
`timescale 1ns/10ps

module alu_op_decoder (
    input  logic [2:0]        funct3,
    input  logic              funct7_b5,
    input  logic              is_reg,
    output decode_pkg::ctrl_t ctrl
);
    import decode_pkg::*;

    logic    valid;
    alu_op_e op;
    logic    sgn;

    always_comb begin
        valid = !(is_reg && funct7_b5);              // register forms want funct7 zero
        op    = alu_add;
        sgn   = 1'b0;
        case (funct3)
            3'b000: begin                            // add, sub, addi
                op    = (is_reg && funct7_b5) ? alu_sub : alu_add;
                valid = 1'b1;
            end
            3'b001: begin                            // sll, slli
                op    = alu_sll;
                valid = !funct7_b5;
            end
            3'b010: begin                            // slt, slti
                op  = alu_slt;
                sgn = 1'b1;
            end
            3'b011:  op = alu_slt;                   // sltu, sltiu
            3'b100:  op = alu_xor;
            3'b101: begin                            // srl, sra, srli, srai
                op    = alu_srl;
                sgn   = funct7_b5;
                valid = 1'b1;
            end
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
    end

    // result of rs1 op rs2/imm goes to rd
    always_comb begin
        ctrl = ctrl_default;
        if (valid) begin
            ctrl.reg_wen   = 1'b1;
            ctrl.a_src     = a_rs1;
            ctrl.b_src     = is_reg ? b_rs2 : b_imm;
            ctrl.alu_op    = op;
            ctrl.wb_src    = wb_alu;
            ctrl.is_signed = sgn;
        end
    end

endmodule

// File: decoder/format_classifier.sv
`timescale 1ns/10ps

module format_classifier (
    input  logic [6:0]             opcode,
    output decode_pkg::imm_type_e  imm_type,
    output decode_pkg::itype_sub_e itype_sub
);
    import decode_pkg::*;

    // immediate format per major opcode
    always_comb begin
        case (opcode)
            opc_lui,
            opc_auipc:    imm_type = imm_u;
            opc_jal:      imm_type = imm_j;
            opc_jalr,
            opc_op_imm,
            opc_load,
            opc_misc_mem,
            opc_system:   imm_type = imm_i;
            opc_branch:   imm_type = imm_b;
            opc_store:    imm_type = imm_s;
            opc_op:       imm_type = imm_r;
            default:      imm_type = imm_unused;
        endcase
    end

    // I-type subclass, only meaningful when imm_type is imm_i
    always_comb begin
        case (opcode)
            opc_jalr:   itype_sub = isub_uncond_jump;
            opc_load:   itype_sub = isub_load;
            opc_op_imm: itype_sub = isub_operation;
            default:    itype_sub = isub_other;      // fence, system, non I-type
        endcase
    end

endmodule

// File: design/inst_fifo.sv
`timescale 1ns/10ps

module inst_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [decode_pkg::xlen-1:0] push_data,
    input  logic                        pop,
    output logic [decode_pkg::xlen-1:0] pop_data,
    output logic                        empty,
    output logic                        credit
);
    import decode_pkg::*;

    logic [xlen-1:0]       mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [credit_w-1:0]   count;
    logic                  wr_en;
    logic                  rd_en;

    assign empty  = (count == '0);
    assign wr_en  = push && (count != credit_w'(fifo_depth));
    assign rd_en  = pop && !empty;
    assign credit = rd_en;                           // one credit back per removed entry

    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;             // wraps, depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // both or neither
            endcase
        end
    end

endmodule

// File: common/decode_pkg.sv
package decode_pkg;

    localparam int xlen = 32;

    // credit and buffer sizing
    localparam int fifo_depth  = 4;                  // upstream credits after reset
    localparam int out_credits = 4;                  // downstream credits after reset
    localparam int credit_w    = 3;                  // holds 0..4
    localparam int fifo_ptr_w  = $clog2(fifo_depth);

    typedef enum logic [6:0] {
        opc_lui      = 7'b011_0111,
        opc_auipc    = 7'b001_0111,
        opc_jal      = 7'b110_1111,
        opc_jalr     = 7'b110_0111,
        opc_op_imm   = 7'b001_0011,
        opc_load     = 7'b000_0011,
        opc_misc_mem = 7'b000_1111,                  // fence
        opc_system   = 7'b111_0011,                  // ecall, ebreak, csr
        opc_branch   = 7'b110_0011,
        opc_store    = 7'b010_0011,
        opc_op       = 7'b011_0011
    } opcode_e;

    typedef enum logic [2:0] {
        imm_r      = 3'd0,
        imm_i      = 3'd1,
        imm_s      = 3'd2,
        imm_b      = 3'd3,
        imm_u      = 3'd4,
        imm_j      = 3'd5,
        imm_unused = 3'd6                            // unknown opcode
    } imm_type_e;

    // I-type opcodes split by what the instruction does
    typedef enum logic [1:0] {
        isub_uncond_jump = 2'd0,                     // jalr
        isub_load        = 2'd1,
        isub_operation   = 2'd2,
        isub_other       = 2'd3                      // fence and system
    } itype_sub_e;

    typedef enum logic {
        a_rs1 = 1'b0,
        a_pc  = 1'b1
    } a_src_e;

    typedef enum logic {
        b_rs2 = 1'b0,
        b_imm = 1'b1
    } b_src_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_xor  = 4'd4,
        alu_srl  = 4'd5,                             // also sra, see is_signed
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_pass = 4'd8                              // operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_alu  = 2'd1,
        wb_mem  = 2'd2,
        wb_snpc = 2'd3                               // pc + 4 for jumps
    } wb_src_e;

    typedef enum logic [1:0] {
        size_none = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } data_size_e;

    typedef struct packed {
        logic       reg_wen;
        a_src_e     a_src;
        b_src_e     b_src;
        alu_op_e    alu_op;
        logic       mem_write;                       // 0 is read
        wb_src_e    wb_src;
        logic       is_signed;
        data_size_e data_size;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] inst;
        ctrl_t           ctrl;
        imm_type_e       imm_type;
        logic [2:0]      br_op;                      // funct3
        logic            is_br;
        logic            is_jal;
        logic            is_jalr;
    } decoded_t;

    // safe bundle, writes nothing anywhere
    localparam ctrl_t ctrl_default = '{
        reg_wen:   1'b0,
        a_src:     a_rs1,
        b_src:     b_rs2,
        alu_op:    alu_add,
        mem_write: 1'b0,
        wb_src:    wb_none,
        is_signed: 1'b0,
        data_size: size_none
    };

endpackage
